//--- hdl/isa_pkg.sv
package isa_pkg;

	// Operation subtype from decode.
	// Encodings follow the decode stage opcode map.
	typedef enum logic [7:0]
	{
		OP_NOP   = 8'b0000_0000,
		// Logic operations.
		OP_OR    = 8'b0010_0101,
		OP_AND   = 8'b0010_0100,
		OP_NOR   = 8'b0010_0111,
		OP_XOR   = 8'b0010_0110,
		// Shifts.
		OP_SLL   = 8'b0111_1100,
		OP_SRL   = 8'b0000_0010,
		OP_SRA   = 8'b0000_0011,
		// Add and subtract.
		OP_ADD   = 8'b0010_0000,
		OP_ADDI  = 8'b0101_0101,
		OP_ADDU  = 8'b0010_0001,
		OP_ADDIU = 8'b0101_0110,
		OP_SUB   = 8'b0010_0010,
		OP_SUBU  = 8'b0010_0011,
		// Set on less than.
		OP_SLT   = 8'b0010_1010,
		OP_SLTU  = 8'b0010_1011,
		// Leading-bit counts.
		OP_CLZ   = 8'b1011_0000,
		OP_CLO   = 8'b1011_0001,
		// Multiplies and multiply-accumulate.
		OP_MUL   = 8'b1010_1001,
		OP_MULT  = 8'b0001_1000,
		OP_MULTU = 8'b0001_1001,
		OP_MADD  = 8'b1010_0110,
		OP_MADDU = 8'b1010_1000,
		OP_MSUB  = 8'b1010_1010,
		OP_MSUBU = 8'b1010_1011,
		// HI/LO moves.
		OP_MFHI  = 8'b0001_0000,
		OP_MFLO  = 8'b0001_0010,
		OP_MTHI  = 8'b0001_0001,
		OP_MTLO  = 8'b0001_0011
	} alu_op_t;

	// Result class, picks the write-back source.
	typedef enum logic [2:0]
	{
		SEL_NOP   = 3'b000,
		SEL_LOGIC = 3'b001,
		SEL_SHIFT = 3'b010,
		SEL_MOVE  = 3'b011,
		SEL_ARITH = 3'b100,
		SEL_MUL   = 3'b101
	} alu_sel_t;

endpackage

//--- hdl/datapath_pkg.sv
package datapath_pkg;

	// General register width.
	parameter int WORD_W = 32;

	// Products and the HI/LO pair.
	parameter int DWORD_W = 2 * WORD_W;

	// Register file has 32 entries.
	parameter int REG_ADDR_W = 5;

	// Low operand-1 bits used as shift amount.
	parameter int SHAMT_W = 5;

	// Operand and result word.
	typedef logic [WORD_W-1:0] word_t;

	// Product, accumulator and {HI, LO}.
	typedef logic [DWORD_W-1:0] dword_t;

	// Destination register address.
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

endpackage

//--- hdl/alu_logic_shift.sv
`timescale 1ns/10ps

module alu_logic_shift
(
	input  isa_pkg::alu_op_t    aluop_i,
	input  datapath_pkg::word_t reg1_i,
	input  datapath_pkg::word_t reg2_i,
	output datapath_pkg::word_t logic_res_o,
	output datapath_pkg::word_t shift_res_o
);

	// Shift amount, low bits of operand 1.
	logic [datapath_pkg::SHAMT_W-1:0] shamt;

	assign shamt = reg1_i[datapath_pkg::SHAMT_W-1:0];

	// Bitwise logic.
	always_comb
	begin
		case (aluop_i)
			isa_pkg::OP_OR:
				logic_res_o = reg1_i | reg2_i;
			isa_pkg::OP_AND:
				logic_res_o = reg1_i & reg2_i;
			isa_pkg::OP_NOR:
				logic_res_o = ~(reg1_i | reg2_i);
			isa_pkg::OP_XOR:
				logic_res_o = reg1_i ^ reg2_i;
			// Not a logic op.
			default:
				logic_res_o = '0;
		endcase
	end

	// Shifts move operand 2.
	always_comb
	begin
		case (aluop_i)
			// Zero fill from the right.
			isa_pkg::OP_SLL:
				shift_res_o = reg2_i << shamt;
			// Zero fill from the left.
			isa_pkg::OP_SRL:
				shift_res_o = reg2_i >> shamt;
			// Sign fill from bit 31.
			isa_pkg::OP_SRA:
				shift_res_o = datapath_pkg::word_t'($signed(reg2_i) >>> shamt);
			default:
				shift_res_o = '0;
		endcase
	end

endmodule

//--- hdl/alu_arith.sv
`timescale 1ns/10ps

module alu_arith
(
	input  isa_pkg::alu_op_t    aluop_i,
	input  datapath_pkg::word_t reg1_i,
	input  datapath_pkg::word_t reg2_i,
	output datapath_pkg::word_t arith_res_o,
	output logic                overflow_o
);

	// Subtract path also serves slt.
	logic                sub_op;
	// Operand 2 after optional complement.
	datapath_pkg::word_t opb;
	datapath_pkg::word_t sum;
	logic                lt_signed;
	logic                lt_unsigned;
	// Word scanned for leading bits.
	datapath_pkg::word_t count_src;
	// Counts 0 to 32.
	logic [5:0]          lead_cnt;

	assign sub_op = (aluop_i == isa_pkg::OP_SUB) ||
	                (aluop_i == isa_pkg::OP_SUBU) ||
	                (aluop_i == isa_pkg::OP_SLT);

	// Invert and add one for subtract.
	assign opb = sub_op ? ~reg2_i : reg2_i;
	assign sum = reg1_i + opb + {{(datapath_pkg::WORD_W-1){1'b0}}, sub_op};

	// Addend signs agree, sum sign flips.
	// opb sign is the true addend sign, also for the most negative reg2.
	assign overflow_o = (reg1_i[datapath_pkg::WORD_W-1] == opb[datapath_pkg::WORD_W-1]) &&
	                    (sum[datapath_pkg::WORD_W-1] != reg1_i[datapath_pkg::WORD_W-1]);

	// Opposite signs: the negative one is smaller.
	// Same signs: the difference cannot overflow, so its sign decides.
	assign lt_signed = (reg1_i[datapath_pkg::WORD_W-1] ^ reg2_i[datapath_pkg::WORD_W-1]) ?
	                   reg1_i[datapath_pkg::WORD_W-1] : sum[datapath_pkg::WORD_W-1];
	assign lt_unsigned = reg1_i < reg2_i;

	// clo counts zeros of the inverted word.
	assign count_src = (aluop_i == isa_pkg::OP_CLO) ? ~reg1_i : reg1_i;

	// Highest set bit wins.
	always_comb
	begin
		lead_cnt = 6'd32;
		for (int i = 0; i < datapath_pkg::WORD_W; i++)
		begin
			if (count_src[i])
				lead_cnt = 6'(datapath_pkg::WORD_W - 1 - i);
		end
	end

	// Result for the arithmetic class.
	always_comb
	begin
		case (aluop_i)
			isa_pkg::OP_ADD, isa_pkg::OP_ADDI, isa_pkg::OP_ADDU, isa_pkg::OP_ADDIU,
			isa_pkg::OP_SUB, isa_pkg::OP_SUBU:
				arith_res_o = sum;
			// Compare gives 0 or 1.
			isa_pkg::OP_SLT:
				arith_res_o = {{(datapath_pkg::WORD_W-1){1'b0}}, lt_signed};
			isa_pkg::OP_SLTU:
				arith_res_o = {{(datapath_pkg::WORD_W-1){1'b0}}, lt_unsigned};
			isa_pkg::OP_CLZ, isa_pkg::OP_CLO:
				arith_res_o = {{(datapath_pkg::WORD_W-6){1'b0}}, lead_cnt};
			default:
				arith_res_o = '0;
		endcase
	end

endmodule

//--- hdl/mult_unit.sv
`timescale 1ns/10ps

module mult_unit
(
	input  logic                 clk,
	input  logic                 rst_i,
	input  isa_pkg::alu_op_t     aluop_i,
	input  datapath_pkg::word_t  reg1_i,
	input  datapath_pkg::word_t  reg2_i,
	input  datapath_pkg::word_t  hi_i,
	input  datapath_pkg::word_t  lo_i,
	output datapath_pkg::dword_t mul_res_o,
	output datapath_pkg::dword_t mac_sum_o,
	output logic                 mac_we_o,
	output logic                 stall_o
);

	// Accumulate sequencer states.
	typedef enum logic
	{
		MAC_IDLE,
		MAC_ACCUM
	} mac_state_t;

	mac_state_t           state;
	mac_state_t           state_nxt;
	logic                 signed_op;
	logic                 mac_op;
	logic                 msub_op;
	// Operand magnitudes.
	datapath_pkg::word_t  mag_a;
	datapath_pkg::word_t  mag_b;
	datapath_pkg::dword_t prod_mag;
	// Product saved in the first accumulate cycle.
	datapath_pkg::dword_t mac_prod;

	assign signed_op = (aluop_i == isa_pkg::OP_MUL) ||
	                   (aluop_i == isa_pkg::OP_MULT) ||
	                   (aluop_i == isa_pkg::OP_MADD) ||
	                   (aluop_i == isa_pkg::OP_MSUB);

	assign msub_op = (aluop_i == isa_pkg::OP_MSUB) || (aluop_i == isa_pkg::OP_MSUBU);
	assign mac_op  = msub_op ||
	                 (aluop_i == isa_pkg::OP_MADD) ||
	                 (aluop_i == isa_pkg::OP_MADDU);

	// Negative signed operands go in as magnitudes.
	assign mag_a = (signed_op && reg1_i[datapath_pkg::WORD_W-1]) ? -reg1_i : reg1_i;
	assign mag_b = (signed_op && reg2_i[datapath_pkg::WORD_W-1]) ? -reg2_i : reg2_i;

	assign prod_mag = datapath_pkg::dword_t'(mag_a) * datapath_pkg::dword_t'(mag_b);

	// Sign fix-up on mixed signs.
	assign mul_res_o = (signed_op &&
	                   (reg1_i[datapath_pkg::WORD_W-1] ^ reg2_i[datapath_pkg::WORD_W-1])) ?
	                   -prod_mag : prod_mag;

	// Second cycle adds the old {HI, LO}.
	assign mac_sum_o = mac_prod + {hi_i, lo_i};

	// First cycle stalls, second writes HI/LO.
	assign stall_o  = mac_op && (state == MAC_IDLE);
	assign mac_we_o = mac_op && (state == MAC_ACCUM);

	always_comb
	begin
		state_nxt = state;
		case (state)
			MAC_IDLE:
				if (mac_op)
					state_nxt = MAC_ACCUM;
			// Back to idle, a held op starts over.
			MAC_ACCUM:
				state_nxt = MAC_IDLE;
			default:
				state_nxt = MAC_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
			state <= MAC_IDLE;
		else
			state <= state_nxt;
	end

	// Store product, negated for msub.
	always_ff @(posedge clk)
	begin
		if (stall_o)
			mac_prod <= msub_op ? -mul_res_o : mul_res_o;
	end

endmodule

//--- hdl/hilo_regs.sv
`timescale 1ns/10ps

module hilo_regs
(
	input  logic                 clk,
	input  logic                 rst_i,
	input  isa_pkg::alu_op_t     aluop_i,
	input  datapath_pkg::word_t  reg1_i,
	input  datapath_pkg::dword_t mul_res_i,
	input  datapath_pkg::dword_t mac_sum_i,
	input  logic                 mac_we_i,
	output datapath_pkg::word_t  hi_o,
	output datapath_pkg::word_t  lo_o
);

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			hi_o <= '0;
			lo_o <= '0;
		end
		// Accumulate result in the second cycle.
		else if (mac_we_i)
			{hi_o, lo_o} <= mac_sum_i;
		else
		begin
			case (aluop_i)
				// Full product into the pair.
				isa_pkg::OP_MULT, isa_pkg::OP_MULTU:
					{hi_o, lo_o} <= mul_res_i;
				// Single register moves, other one kept.
				isa_pkg::OP_MTHI:
					hi_o <= reg1_i;
				isa_pkg::OP_MTLO:
					lo_o <= reg1_i;
				default:
				begin
				end
			endcase
		end
	end

endmodule

//--- hdl/exec_unit.sv
`timescale 1ns/10ps

module exec_unit
(
	input  logic                   clk,
	input  logic                   rst_i,
	input  isa_pkg::alu_op_t       aluop_i,
	input  isa_pkg::alu_sel_t      alusel_i,
	input  datapath_pkg::word_t    reg1_i,
	input  datapath_pkg::word_t    reg2_i,
	input  datapath_pkg::reg_addr_t wd_i,
	input  logic                   wreg_i,
	output datapath_pkg::reg_addr_t wd_o,
	output logic                   wreg_o,
	output datapath_pkg::word_t    wdata_o,
	output logic                   stall_o
);

	datapath_pkg::word_t  logic_res;
	datapath_pkg::word_t  shift_res;
	datapath_pkg::word_t  arith_res;
	logic                 overflow;
	datapath_pkg::dword_t mul_res;
	datapath_pkg::dword_t mac_sum;
	logic                 mac_we;
	logic                 stall;
	datapath_pkg::word_t  hi;
	datapath_pkg::word_t  lo;
	// Ops that trap on signed overflow.
	logic                 ov_op;

	alu_logic_shift i_logic_shift
	(
		.aluop_i     (aluop_i),
		.reg1_i      (reg1_i),
		.reg2_i      (reg2_i),
		.logic_res_o (logic_res),
		.shift_res_o (shift_res)
	);

	alu_arith i_arith
	(
		.aluop_i     (aluop_i),
		.reg1_i      (reg1_i),
		.reg2_i      (reg2_i),
		.arith_res_o (arith_res),
		.overflow_o  (overflow)
	);

	mult_unit i_mult
	(
		.clk       (clk),
		.rst_i     (rst_i),
		.aluop_i   (aluop_i),
		.reg1_i    (reg1_i),
		.reg2_i    (reg2_i),
		.hi_i      (hi),
		.lo_i      (lo),
		.mul_res_o (mul_res),
		.mac_sum_o (mac_sum),
		.mac_we_o  (mac_we),
		.stall_o   (stall)
	);

	hilo_regs i_hilo
	(
		.clk       (clk),
		.rst_i     (rst_i),
		.aluop_i   (aluop_i),
		.reg1_i    (reg1_i),
		.mul_res_i (mul_res),
		.mac_sum_i (mac_sum),
		.mac_we_i  (mac_we),
		.hi_o      (hi),
		.lo_o      (lo)
	);

	assign stall_o = stall;
	assign wd_o    = wd_i;

	// Overflow on add, addi or sub drops the write.
	assign ov_op  = (aluop_i == isa_pkg::OP_ADD) ||
	                (aluop_i == isa_pkg::OP_ADDI) ||
	                (aluop_i == isa_pkg::OP_SUB);
	assign wreg_o = (ov_op && overflow) ? 1'b0 : wreg_i;

	// Write-back data by result class.
	always_comb
	begin
		case (alusel_i)
			isa_pkg::SEL_LOGIC:
				wdata_o = logic_res;
			isa_pkg::SEL_SHIFT:
				wdata_o = shift_res;
			isa_pkg::SEL_ARITH:
				wdata_o = arith_res;
			// mfhi or mflo, else zero.
			isa_pkg::SEL_MOVE:
				if (aluop_i == isa_pkg::OP_MFHI)
					wdata_o = hi;
				else if (aluop_i == isa_pkg::OP_MFLO)
					wdata_o = lo;
				else
					wdata_o = '0;
			// mul keeps the low word.
			isa_pkg::SEL_MUL:
				wdata_o = mul_res[datapath_pkg::WORD_W-1:0];
			default:
				wdata_o = '0;
		endcase
	end

endmodule

//--- verification/exec_unit_assertions.sv
`timescale 1ns/10ps

module exec_unit_assertions
(
	input logic             clk,
	input logic             rst_i,
	input isa_pkg::alu_op_t aluop_i,
	input logic             stall_i
);

	// Failures so far.
	int fail_cnt = 0;

	// Sequencer idle after reset.
	a_idle_after_reset: assert property (@(posedge clk) rst_i |=> !stall_i)
	else
	begin
		$error("stall_o high in the cycle after reset");
		fail_cnt++;
	end

	// One stall cycle per accumulate.
	a_single_stall: assert property (@(posedge clk) disable iff (rst_i) stall_i |=> !stall_i)
	else
	begin
		$error("stall_o high for two cycles in a row");
		fail_cnt++;
	end

	// Stall marks the first cycle of each accumulate op and nothing else.
	a_stall_on_mac: assert property (@(posedge clk) disable iff (rst_i)
		stall_i == ((aluop_i inside {isa_pkg::OP_MADD, isa_pkg::OP_MADDU,
		                             isa_pkg::OP_MSUB, isa_pkg::OP_MSUBU}) &&
		            !$past(stall_i)))
	else
	begin
		$error("stall_o does not follow the first cycle of an accumulate op");
		fail_cnt++;
	end

endmodule

bind exec_unit exec_unit_assertions i_assert
(
	.clk     (clk),
	.rst_i   (rst_i),
	.aluop_i (aluop_i),
	.stall_i (stall_o)
);

//--- verification/exec_unit_tb.sv
`timescale 1ns/10ps

module exec_unit_tb;

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 16;
	// Cycles each test needs.
	localparam int RESET_TEST_CYCLES = 2;
	localparam int LOGIC_TEST_CYCLES = 58;
	localparam int ARITH_TEST_CYCLES = 60;
	localparam int COUNT_TEST_CYCLES = 84;
	localparam int MULT_TEST_CYCLES = 42;
	localparam int MAC_TEST_CYCLES = 48;
	localparam int MARGIN_CYCLES = 100;
	localparam int TIMEOUT_NS = CLK_PERIOD * (RESET_CYCLES + 1 + RESET_TEST_CYCLES +
		LOGIC_TEST_CYCLES + ARITH_TEST_CYCLES + COUNT_TEST_CYCLES + MULT_TEST_CYCLES +
		MAC_TEST_CYCLES + MARGIN_CYCLES);

	logic                    clk;
	logic                    rst_i;
	isa_pkg::alu_op_t        aluop;
	isa_pkg::alu_sel_t       alusel;
	datapath_pkg::word_t     reg1;
	datapath_pkg::word_t     reg2;
	datapath_pkg::reg_addr_t wd;
	logic                    wreg;
	datapath_pkg::reg_addr_t wd_o;
	logic                    wreg_o;
	datapath_pkg::word_t     wdata_o;
	logic                    stall_o;
	// Expected HI/LO.
	datapath_pkg::word_t     exp_hi;
	datapath_pkg::word_t     exp_lo;
	logic [31:0]             lfsr;
	int                      errors;
	int                      tests_run;
	int                      tests_failed;

	exec_unit i_dut
	(
		.clk      (clk),
		.rst_i    (rst_i),
		.aluop_i  (aluop),
		.alusel_i (alusel),
		.reg1_i   (reg1),
		.reg2_i   (reg2),
		.wd_i     (wd),
		.wreg_i   (wreg),
		.wd_o     (wd_o),
		.wreg_o   (wreg_o),
		.wdata_o  (wdata_o),
		.stall_o  (stall_o)
	);

	// Galois LFSR taps for x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One step per bit taken.
	function automatic datapath_pkg::word_t rand_bits(input int n);
		datapath_pkg::word_t v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[datapath_pkg::WORD_W-2:0], lfsr[0]};
		end
		return v;
	endfunction

	// Result class as decode sends it.
	function automatic isa_pkg::alu_sel_t sel_of(input isa_pkg::alu_op_t op);
		case (op)
			isa_pkg::OP_OR, isa_pkg::OP_AND, isa_pkg::OP_NOR, isa_pkg::OP_XOR:
				return isa_pkg::SEL_LOGIC;
			isa_pkg::OP_SLL, isa_pkg::OP_SRL, isa_pkg::OP_SRA:
				return isa_pkg::SEL_SHIFT;
			isa_pkg::OP_ADD, isa_pkg::OP_ADDI, isa_pkg::OP_ADDU, isa_pkg::OP_ADDIU,
			isa_pkg::OP_SUB, isa_pkg::OP_SUBU, isa_pkg::OP_SLT, isa_pkg::OP_SLTU,
			isa_pkg::OP_CLZ, isa_pkg::OP_CLO:
				return isa_pkg::SEL_ARITH;
			isa_pkg::OP_MFHI, isa_pkg::OP_MFLO:
				return isa_pkg::SEL_MOVE;
			isa_pkg::OP_MUL:
				return isa_pkg::SEL_MUL;
			// No register write.
			default:
				return isa_pkg::SEL_NOP;
		endcase
	endfunction

	// Full 64-bit product.
	function automatic datapath_pkg::dword_t product(input isa_pkg::alu_op_t op,
		input datapath_pkg::word_t a, input datapath_pkg::word_t b);
		longint sa;
		longint sb;
		if (op == isa_pkg::OP_MULTU || op == isa_pkg::OP_MADDU || op == isa_pkg::OP_MSUBU)
			return {32'b0, a} * {32'b0, b};
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		return datapath_pkg::dword_t'(sa * sb);
	endfunction

	// Length of the run of lead bits from bit 31 down.
	function automatic datapath_pkg::word_t lead_count(input datapath_pkg::word_t v,
		input logic lead);
		int n;
		n = 0;
		while (n < 32 && v[31 - n] == lead)
			n++;
		return datapath_pkg::word_t'(n);
	endfunction

	// Expected write-back data.
	function automatic datapath_pkg::word_t model_result(input isa_pkg::alu_op_t op,
		input datapath_pkg::word_t a, input datapath_pkg::word_t b);
		datapath_pkg::dword_t p;
		logic [4:0]           sh;
		sh = a[4:0];
		p = product(op, a, b);
		case (op)
			isa_pkg::OP_OR:
				return a | b;
			isa_pkg::OP_AND:
				return a & b;
			isa_pkg::OP_NOR:
				return ~(a | b);
			isa_pkg::OP_XOR:
				return a ^ b;
			isa_pkg::OP_SLL:
				return b << sh;
			isa_pkg::OP_SRL:
				return b >> sh;
			// Vacated top bits take the sign.
			isa_pkg::OP_SRA:
				return (b >> sh) | (b[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
			isa_pkg::OP_ADD, isa_pkg::OP_ADDI, isa_pkg::OP_ADDU, isa_pkg::OP_ADDIU:
				return a + b;
			isa_pkg::OP_SUB, isa_pkg::OP_SUBU:
				return a - b;
			isa_pkg::OP_SLT:
				return {31'b0, $signed(a) < $signed(b)};
			isa_pkg::OP_SLTU:
				return {31'b0, a < b};
			isa_pkg::OP_CLZ:
				return lead_count(a, 1'b0);
			isa_pkg::OP_CLO:
				return lead_count(a, 1'b1);
			isa_pkg::OP_MUL:
				return p[31:0];
			isa_pkg::OP_MFHI:
				return exp_hi;
			isa_pkg::OP_MFLO:
				return exp_lo;
			default:
				return '0;
		endcase
	endfunction

	// Write dropped when the true result leaves the signed word range.
	function automatic logic model_wreg(input isa_pkg::alu_op_t op,
		input datapath_pkg::word_t a, input datapath_pkg::word_t b, input logic we);
		longint r;
		if (op == isa_pkg::OP_ADD || op == isa_pkg::OP_ADDI)
			r = longint'($signed(a)) + longint'($signed(b));
		else if (op == isa_pkg::OP_SUB)
			r = longint'($signed(a)) - longint'($signed(b));
		else
			return we;
		return (r != longint'($signed(r[31:0]))) ? 1'b0 : we;
	endfunction

	task automatic compare_word(input string name, input datapath_pkg::word_t exp,
		input datapath_pkg::word_t act);
		if (exp !== act)
		begin
			$display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic compare_addr(input string name, input datapath_pkg::reg_addr_t exp,
		input datapath_pkg::reg_addr_t act);
		if (exp !== act)
		begin
			$display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic compare_bit(input string name, input logic exp, input logic act);
		if (exp !== act)
		begin
			$display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
			errors++;
		end
	endtask

	// Inputs change on the falling edge.
	task automatic drive_op(input isa_pkg::alu_op_t op, input datapath_pkg::word_t a,
		input datapath_pkg::word_t b, input logic we);
		@(negedge clk);
		aluop = op;
		alusel = sel_of(op);
		reg1 = a;
		reg2 = b;
		wd = datapath_pkg::reg_addr_t'(rand_bits(5));
		wreg = we;
	endtask

	// Model HI/LO after a single-cycle op.
	task automatic update_hilo(input isa_pkg::alu_op_t op, input datapath_pkg::word_t a,
		input datapath_pkg::word_t b);
		if (op == isa_pkg::OP_MULT || op == isa_pkg::OP_MULTU)
			{exp_hi, exp_lo} = product(op, a, b);
		else if (op == isa_pkg::OP_MTHI)
			exp_hi = a;
		else if (op == isa_pkg::OP_MTLO)
			exp_lo = a;
	endtask

	// Single-cycle op sampled 1 ns before the rising edge.
	task automatic exec_check(input isa_pkg::alu_op_t op, input datapath_pkg::word_t a,
		input datapath_pkg::word_t b);
		logic we;
		we = (sel_of(op) != isa_pkg::SEL_NOP);
		drive_op(op, a, b, we);
		#(CLK_PERIOD / 2 - 1);
		compare_addr("wd_o", wd, wd_o);
		compare_bit("wreg_o", model_wreg(op, a, b, we), wreg_o);
		compare_word("wdata_o", model_result(op, a, b), wdata_o);
		compare_bit("stall_o", 1'b0, stall_o);
		update_hilo(op, a, b);
	endtask

	task automatic read_hilo();
		exec_check(isa_pkg::OP_MFHI, rand_bits(32), rand_bits(32));
		exec_check(isa_pkg::OP_MFLO, rand_bits(32), rand_bits(32));
	endtask

	// Accumulate op held while stall_o is high.
	task automatic mac_check(input isa_pkg::alu_op_t op, input datapath_pkg::word_t a,
		input datapath_pkg::word_t b);
		datapath_pkg::dword_t acc;
		int                   stall_cycles;
		drive_op(op, a, b, 1'b0);
		#(CLK_PERIOD / 2 - 1);
		stall_cycles = 0;
		while (stall_o === 1'b1 && stall_cycles < 4)
		begin
			stall_cycles++;
			@(negedge clk);
			#(CLK_PERIOD / 2 - 1);
		end
		if (stall_cycles != 1)
		begin
			$display("%s kept stall_o high for %0d cycles, one expected",
				op.name(), stall_cycles);
			errors++;
		end
		compare_addr("wd_o", wd, wd_o);
		compare_bit("wreg_o", 1'b0, wreg_o);
		compare_word("wdata_o", '0, wdata_o);
		acc = product(op, a, b);
		if (op == isa_pkg::OP_MSUB || op == isa_pkg::OP_MSUBU)
			acc = -acc;
		{exp_hi, exp_lo} = {exp_hi, exp_lo} + acc;
	endtask

	task automatic mac_round(input isa_pkg::alu_op_t op);
		exec_check(isa_pkg::OP_MTHI, rand_bits(32), '0);
		exec_check(isa_pkg::OP_MTLO, rand_bits(32), '0);
		mac_check(op, rand_bits(32), rand_bits(32));
		read_hilo();
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before)
			$display("Test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("Test %s: %0d errors", name, errors - errors_before);
		end
	endtask

	// HI/LO read as zero.
	task automatic test_reset();
		int e0;
		e0 = errors;
		read_hilo();
		finish_test("reset", e0);
	endtask

	task automatic test_logic_shift();
		int e0;
		e0 = errors;
		for (int i = 0; i < 8; i++)
		begin
			exec_check(isa_pkg::OP_OR, rand_bits(32), rand_bits(32));
			exec_check(isa_pkg::OP_AND, rand_bits(32), rand_bits(32));
			exec_check(isa_pkg::OP_NOR, rand_bits(32), rand_bits(32));
			exec_check(isa_pkg::OP_XOR, rand_bits(32), rand_bits(32));
			exec_check(isa_pkg::OP_SLL, rand_bits(32), rand_bits(32));
			exec_check(isa_pkg::OP_SRL, rand_bits(32), rand_bits(32));
			exec_check(isa_pkg::OP_SRA, rand_bits(32), rand_bits(32));
		end
		// Shift amount 4 with the upper reg1 bits set.
		exec_check(isa_pkg::OP_SRA, 32'hffff_ffe4, 32'h8000_0f00);
		exec_check(isa_pkg::OP_SRL, 32'hffff_ffe4, 32'h8000_0f00);
		finish_test("logic_shift", e0);
	endtask

	task automatic test_arith();
		int e0;
		e0 = errors;
		// Overflow in both directions.
		exec_check(isa_pkg::OP_ADD, 32'h7fff_ffff, 32'h0000_0001);
		exec_check(isa_pkg::OP_ADDI, 32'h8000_0000, 32'hffff_ffff);
		exec_check(isa_pkg::OP_SUB, 32'h8000_0000, 32'h0000_0001);
		exec_check(isa_pkg::OP_SUB, 32'h7fff_ffff, 32'hffff_fffe);
		// Same operands wrap without trapping.
		exec_check(isa_pkg::OP_ADDU, 32'h7fff_ffff, 32'h0000_0001);
		exec_check(isa_pkg::OP_ADDIU, 32'h8000_0000, 32'hffff_ffff);
		exec_check(isa_pkg::OP_SUBU, 32'h8000_0000, 32'h0000_0001);
		exec_check(isa_pkg::OP_SUBU, 32'h7fff_ffff, 32'hffff_fffe);
		// Opposite signs split slt and sltu.
		exec_check(isa_pkg::OP_SLT, 32'hffff_fffe, 32'h0000_0001);
		exec_check(isa_pkg::OP_SLTU, 32'hffff_fffe, 32'h0000_0001);
		exec_check(isa_pkg::OP_SLT, 32'h0000_0001, 32'h8000_0000);
		exec_check(isa_pkg::OP_SLTU, 32'h0000_0001, 32'h8000_0000);
		for (int i = 0; i < 8; i++)
		begin
			exec_check(isa_pkg::OP_ADD, rand_bits(32), rand_bits(32));
			exec_check(isa_pkg::OP_ADDU, rand_bits(32), rand_bits(32));
			exec_check(isa_pkg::OP_SUB, rand_bits(32), rand_bits(32));
			exec_check(isa_pkg::OP_SUBU, rand_bits(32), rand_bits(32));
			exec_check(isa_pkg::OP_SLT, rand_bits(32), rand_bits(32));
			exec_check(isa_pkg::OP_SLTU, rand_bits(32), rand_bits(32));
		end
		finish_test("arith", e0);
	endtask

	task automatic test_counts();
		int e0;
		e0 = errors;
		exec_check(isa_pkg::OP_CLZ, 32'h0, '0);
		exec_check(isa_pkg::OP_CLO, 32'h0, '0);
		exec_check(isa_pkg::OP_CLZ, 32'hffff_ffff, '0);
		exec_check(isa_pkg::OP_CLO, 32'hffff_ffff, '0);
		for (int i = 0; i < 32; i++)
		begin
			exec_check(isa_pkg::OP_CLZ, 32'h1 << i, '0);
			exec_check(isa_pkg::OP_CLO, ~(32'h1 << i), '0);
		end
		// Random words shifted for varied counts.
		for (int i = 0; i < 8; i++)
		begin
			exec_check(isa_pkg::OP_CLZ, rand_bits(32) >> rand_bits(5), '0);
			exec_check(isa_pkg::OP_CLO, ~(rand_bits(32) >> rand_bits(5)), '0);
		end
		finish_test("counts", e0);
	endtask

	task automatic test_mult_hilo();
		int e0;
		e0 = errors;
		for (int i = 0; i < 4; i++)
		begin
			exec_check(isa_pkg::OP_MULT, rand_bits(32), rand_bits(32));
			read_hilo();
			exec_check(isa_pkg::OP_MULTU, rand_bits(32), rand_bits(32));
			read_hilo();
		end
		exec_check(isa_pkg::OP_MULT, 32'hffff_fff9, 32'hffff_fffd);
		read_hilo();
		exec_check(isa_pkg::OP_MULT, 32'h8000_0000, 32'h0000_0003);
		read_hilo();
		exec_check(isa_pkg::OP_MULTU, 32'hffff_ffff, 32'hffff_ffff);
		read_hilo();
		// mul leaves the pair alone.
		exec_check(isa_pkg::OP_MUL, rand_bits(32), rand_bits(32));
		read_hilo();
		exec_check(isa_pkg::OP_MTHI, rand_bits(32), '0);
		read_hilo();
		exec_check(isa_pkg::OP_MTLO, rand_bits(32), '0);
		read_hilo();
		finish_test("mult_hilo", e0);
	endtask

	task automatic test_mac();
		int e0;
		e0 = errors;
		for (int i = 0; i < 2; i++)
		begin
			mac_round(isa_pkg::OP_MADD);
			mac_round(isa_pkg::OP_MADDU);
			mac_round(isa_pkg::OP_MSUB);
			mac_round(isa_pkg::OP_MSUBU);
		end
		finish_test("mac", e0);
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	// Stuck run guard.
	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: tests still running after %0d ns", TIMEOUT_NS);
		$display("Some tests failed");
		$finish;
	end

	initial
	begin
		lfsr = 32'heab7_c9e2;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		exp_hi = '0;
		exp_lo = '0;
		rst_i = 1'b1;
		aluop = isa_pkg::OP_NOP;
		alusel = isa_pkg::SEL_NOP;
		reg1 = '0;
		reg2 = '0;
		wd = '0;
		wreg = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;
		test_reset();
		test_logic_shift();
		test_arith();
		test_counts();
		test_mult_hilo();
		test_mac();
		errors += i_dut.i_assert.fail_cnt;
		$display("Tests run: %0d, failed: %0d, errors: %0d, assertion failures: %0d",
			tests_run, tests_failed, errors, i_dut.i_assert.fail_cnt);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- files.f
hdl/isa_pkg.sv
hdl/datapath_pkg.sv
hdl/alu_logic_shift.sv
hdl/alu_arith.sv
hdl/mult_unit.sv
hdl/hilo_regs.sv
hdl/exec_unit.sv
verification/exec_unit_assertions.sv
verification/exec_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass message in the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module exec_unit_tb -f files.f \
	|| { echo "Build failed"; exit 1; }

./obj_dir/Vexec_unit_tb +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

grep -q "All tests passed" sim.log && echo "Simulation PASS" \
	|| { echo "Simulation FAIL"; exit 1; }
